//--- logic/br_consts.svh
`ifndef BR_CONSTS_SVH
`define BR_CONSTS_SVH

////////////////////////////////////////////////////////////
// branch reservation station sizing
////////////////////////////////////////////////////////////

`define BR_RS_DEPTH 4
`define BR_RS_IDX   2

// broadcast lanes, lane 0 is the branch link write
`define CDB_WIDTH   2

////////////////////////////////////////////////////////////
// machine widths
////////////////////////////////////////////////////////////

`define PRF_DEPTH   64
`define PRF_IDX     6
`define ARF_IDX     5
`define ROB_IDX     5
`define XLEN        32

`endif

//--- logic/cpu_types_pkg.sv
`default_nettype none

`include "br_consts.svh"

package cpu_types_pkg;

    // data, pc and immediate values
    typedef logic [`XLEN-1:0]    word_t;

    // physical register number
    typedef logic [`PRF_IDX-1:0] prf_idx_t;

    // architectural register number
    typedef logic [`ARF_IDX-1:0] arf_idx_t;

    // reorder buffer tag
    typedef logic [`ROB_IDX-1:0] rob_id_t;

endpackage

`default_nettype wire

//--- logic/br_uop_pkg.sv
`default_nettype none

`include "br_consts.svh"

package br_uop_pkg;

    typedef logic [3:0] br_op_t;

    // conditional branches, low bits follow funct3
    localparam br_op_t BR_BEQ  = 4'h0;
    localparam br_op_t BR_BNE  = 4'h1;
    localparam br_op_t BR_BLT  = 4'h4;
    localparam br_op_t BR_BGE  = 4'h5;
    localparam br_op_t BR_BLTU = 4'h6;
    localparam br_op_t BR_BGEU = 4'h7;

    // unconditional jumps with link
    localparam br_op_t BR_JAL  = 4'h8;
    localparam br_op_t BR_JALR = 4'h9;

    // reservation station slot index
    typedef logic [`BR_RS_IDX-1:0] rs_slot_t;

endpackage

`default_nettype wire

//--- logic/fu_br.sv
`timescale 1ns/100ps
`default_nettype none

module fu_br (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     issue_valid,
    input  cpu_types_pkg::rob_id_t   issue_rob_id,
    input  cpu_types_pkg::prf_idx_t  issue_rd_phy,
    input  cpu_types_pkg::arf_idx_t  issue_rd_arch,
    input  br_uop_pkg::br_op_t       issue_op,
    input  cpu_types_pkg::word_t     issue_imm,
    input  cpu_types_pkg::word_t     issue_pc,
    input  logic                     issue_pred_taken,
    input  cpu_types_pkg::word_t     issue_pred_target,
    input  cpu_types_pkg::word_t     issue_rs1_value,
    input  cpu_types_pkg::word_t     issue_rs2_value,

    output logic                     resolve_valid,
    output cpu_types_pkg::rob_id_t   resolve_rob_id,
    output logic                     resolve_taken,
    output cpu_types_pkg::word_t     resolve_target,
    output logic                     resolve_mispredict,
    output logic                     cdb_valid,
    output cpu_types_pkg::prf_idx_t  cdb_rd_phy,
    output cpu_types_pkg::word_t     cdb_value
);
    import cpu_types_pkg::*;
    import br_uop_pkg::*;

    logic  taken;
    logic  is_jump;
    logic  mispredict;
    word_t pc_plus4;
    word_t target;

    always_comb begin
        pc_plus4 = issue_pc + word_t'(4);
        is_jump  = (issue_op == BR_JAL) || (issue_op == BR_JALR);

        case (issue_op)
            BR_BEQ:  taken = (issue_rs1_value == issue_rs2_value);
            BR_BNE:  taken = (issue_rs1_value != issue_rs2_value);
            BR_BLT:  taken = ($signed(issue_rs1_value) < $signed(issue_rs2_value));
            BR_BGE:  taken = ($signed(issue_rs1_value) >= $signed(issue_rs2_value));
            BR_BLTU: taken = (issue_rs1_value < issue_rs2_value);
            BR_BGEU: taken = (issue_rs1_value >= issue_rs2_value);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        // jalr target has bit 0 cleared
        if (issue_op == BR_JALR) begin
            target = (issue_rs1_value + issue_imm) & ~word_t'(1);
        end else if (taken) begin
            target = issue_pc + issue_imm;
        end else begin
            target = pc_plus4;
        end

        mispredict = (issue_pred_taken != taken)
            || (taken && (issue_pred_target != target));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resolve_valid <= 1'b0;
            cdb_valid     <= 1'b0;
        end else begin
            resolve_valid <= issue_valid;
            // no link write for x0
            cdb_valid     <= issue_valid && is_jump && (issue_rd_arch != '0);
        end
    end

    always_ff @(posedge clk) begin
        resolve_rob_id     <= issue_rob_id;
        resolve_taken      <= taken;
        resolve_target     <= target;
        resolve_mispredict <= mispredict;
        cdb_rd_phy         <= issue_rd_phy;
        cdb_value          <= pc_plus4;
    end

endmodule

`default_nettype wire

//--- logic/prf_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_consts.svh"

module prf_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lane_valid [`CDB_WIDTH],
    input  cpu_types_pkg::prf_idx_t  lane_phy   [`CDB_WIDTH],
    input  cpu_types_pkg::word_t     lane_value [`CDB_WIDTH],
    input  cpu_types_pkg::prf_idx_t  rd1_phy,
    input  cpu_types_pkg::prf_idx_t  rd2_phy,
    output cpu_types_pkg::word_t     rd1_value,
    output cpu_types_pkg::word_t     rd2_value
);
    import cpu_types_pkg::*;

    word_t regs [`PRF_DEPTH];

    // lanes scanned high to low so lane 0 wins a collision
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = `CDB_WIDTH - 1; k >= 0; k--) begin
                if (lane_valid[k]) begin
                    regs[lane_phy[k]] <= lane_value[k];
                end
            end
        end
    end

    // stored word, or the write landing this cycle
    function automatic word_t read_port(input prf_idx_t idx);
        word_t value;
        value = regs[idx];
        for (int k = `CDB_WIDTH - 1; k >= 0; k--) begin
            if (lane_valid[k] && (lane_phy[k] == idx)) begin
                value = lane_value[k];
            end
        end
        return value;
    endfunction

    always_comb begin
        rd1_value = read_port(rd1_phy);
        rd2_value = read_port(rd2_phy);
    end

endmodule

`default_nettype wire

//--- logic/br_rs.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_consts.svh"

module br_rs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     branch_ready,

    input  logic                     disp_valid,
    output logic                     disp_ready,
    input  cpu_types_pkg::rob_id_t   disp_rob_id,
    input  cpu_types_pkg::prf_idx_t  disp_rs1_phy,
    input  logic                     disp_rs1_ready,
    input  cpu_types_pkg::prf_idx_t  disp_rs2_phy,
    input  logic                     disp_rs2_ready,
    input  cpu_types_pkg::prf_idx_t  disp_rd_phy,
    input  cpu_types_pkg::arf_idx_t  disp_rd_arch,
    input  cpu_types_pkg::word_t     disp_imm,
    input  cpu_types_pkg::word_t     disp_pc,
    input  br_uop_pkg::br_op_t       disp_op,
    input  logic                     disp_pred_taken,
    input  cpu_types_pkg::word_t     disp_pred_target,

    input  logic                     lane_valid [`CDB_WIDTH],
    input  cpu_types_pkg::prf_idx_t  lane_phy   [`CDB_WIDTH],
    input  cpu_types_pkg::word_t     lane_value [`CDB_WIDTH],

    output cpu_types_pkg::prf_idx_t  rd1_phy,
    output cpu_types_pkg::prf_idx_t  rd2_phy,
    input  cpu_types_pkg::word_t     rd1_value,
    input  cpu_types_pkg::word_t     rd2_value,

    output logic                     cdb_valid,
    output cpu_types_pkg::prf_idx_t  cdb_rd_phy,
    output cpu_types_pkg::word_t     cdb_value,
    output logic                     resolve_valid,
    output cpu_types_pkg::rob_id_t   resolve_rob_id,
    output logic                     resolve_taken,
    output cpu_types_pkg::word_t     resolve_target,
    output logic                     resolve_mispredict
);
    import cpu_types_pkg::*;
    import br_uop_pkg::*;

    ////////////////////////////////////////////////////////////
    // slot storage
    ////////////////////////////////////////////////////////////

    logic [`BR_RS_DEPTH-1:0] slot_free;
    logic [`BR_RS_DEPTH-1:0] slot_rs1_rdy;
    logic [`BR_RS_DEPTH-1:0] slot_rs2_rdy;
    logic [`BR_RS_DEPTH-1:0] slot_ready;

    rob_id_t  slot_rob_id      [`BR_RS_DEPTH];
    prf_idx_t slot_rs1_phy     [`BR_RS_DEPTH];
    prf_idx_t slot_rs2_phy     [`BR_RS_DEPTH];
    prf_idx_t slot_rd_phy      [`BR_RS_DEPTH];
    arf_idx_t slot_rd_arch     [`BR_RS_DEPTH];
    word_t    slot_imm         [`BR_RS_DEPTH];
    word_t    slot_pc          [`BR_RS_DEPTH];
    br_op_t   slot_op          [`BR_RS_DEPTH];
    logic     slot_pred_taken  [`BR_RS_DEPTH];
    word_t    slot_pred_target [`BR_RS_DEPTH];

    logic     push_en;
    rs_slot_t push_idx;
    logic     issue_valid;
    rs_slot_t issue_idx;

    // any valid broadcast lane writing this tag
    function automatic logic lane_hit(input prf_idx_t tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (lane_valid[k] && (lane_phy[k] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign disp_ready = |slot_free;
    assign push_en    = disp_valid && disp_ready && branch_ready;

    // lowest free slot takes the push
    always_comb begin
        push_idx = '0;
        for (int i = `BR_RS_DEPTH - 1; i >= 0; i--) begin
            if (slot_free[i]) begin
                push_idx = rs_slot_t'(i);
            end
        end
    end

    // ready now, counting this cycle's broadcast
    always_comb begin
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            slot_ready[i] = !slot_free[i]
                && (slot_rs1_rdy[i] || lane_hit(slot_rs1_phy[i]))
                && (slot_rs2_rdy[i] || lane_hit(slot_rs2_phy[i]));
        end
    end

    // oldest slot first means lowest index here
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = `BR_RS_DEPTH - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                issue_valid = 1'b1;
                issue_idx   = rs_slot_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_free <= '1;
        end else begin
            if (push_en) begin
                slot_free[push_idx] <= 1'b0;
            end
            if (issue_valid) begin
                slot_free[issue_idx] <= 1'b1;
            end
        end
    end

    // push writes a free slot, snoop only touches occupied ones
    always_ff @(posedge clk) begin
        if (push_en) begin
            slot_rob_id[push_idx]      <= disp_rob_id;
            slot_rs1_phy[push_idx]     <= disp_rs1_phy;
            slot_rs2_phy[push_idx]     <= disp_rs2_phy;
            slot_rs1_rdy[push_idx]     <= disp_rs1_ready || lane_hit(disp_rs1_phy);
            slot_rs2_rdy[push_idx]     <= disp_rs2_ready || lane_hit(disp_rs2_phy);
            slot_rd_phy[push_idx]      <= disp_rd_phy;
            slot_rd_arch[push_idx]     <= disp_rd_arch;
            slot_imm[push_idx]         <= disp_imm;
            slot_pc[push_idx]          <= disp_pc;
            slot_op[push_idx]          <= disp_op;
            slot_pred_taken[push_idx]  <= disp_pred_taken;
            slot_pred_target[push_idx] <= disp_pred_target;
        end
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            if (!slot_free[i] && lane_hit(slot_rs1_phy[i])) begin
                slot_rs1_rdy[i] <= 1'b1;
            end
            if (!slot_free[i] && lane_hit(slot_rs2_phy[i])) begin
                slot_rs2_rdy[i] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // operand read and issue
    ////////////////////////////////////////////////////////////

    assign rd1_phy = slot_rs1_phy[issue_idx];
    assign rd2_phy = slot_rs2_phy[issue_idx];

    fu_br fu_br_i (
        .clk                (clk),
        .rst                (rst),
        .issue_valid        (issue_valid),
        .issue_rob_id       (slot_rob_id[issue_idx]),
        .issue_rd_phy       (slot_rd_phy[issue_idx]),
        .issue_rd_arch      (slot_rd_arch[issue_idx]),
        .issue_op           (slot_op[issue_idx]),
        .issue_imm          (slot_imm[issue_idx]),
        .issue_pc           (slot_pc[issue_idx]),
        .issue_pred_taken   (slot_pred_taken[issue_idx]),
        .issue_pred_target  (slot_pred_target[issue_idx]),
        .issue_rs1_value    (rd1_value),
        .issue_rs2_value    (rd2_value),
        .resolve_valid      (resolve_valid),
        .resolve_rob_id     (resolve_rob_id),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_mispredict (resolve_mispredict),
        .cdb_valid          (cdb_valid),
        .cdb_rd_phy         (cdb_rd_phy),
        .cdb_value          (cdb_value)
    );

endmodule

`default_nettype wire

//--- logic/br_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_consts.svh"

module br_issue_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     branch_ready,

    input  logic                     disp_valid,
    output logic                     disp_ready,
    input  cpu_types_pkg::rob_id_t   disp_rob_id,
    input  cpu_types_pkg::prf_idx_t  disp_rs1_phy,
    input  logic                     disp_rs1_ready,
    input  cpu_types_pkg::prf_idx_t  disp_rs2_phy,
    input  logic                     disp_rs2_ready,
    input  cpu_types_pkg::prf_idx_t  disp_rd_phy,
    input  cpu_types_pkg::arf_idx_t  disp_rd_arch,
    input  cpu_types_pkg::word_t     disp_imm,
    input  cpu_types_pkg::word_t     disp_pc,
    input  br_uop_pkg::br_op_t       disp_op,
    input  logic                     disp_pred_taken,
    input  cpu_types_pkg::word_t     disp_pred_target,

    input  logic                     ext_wr_valid,
    input  cpu_types_pkg::prf_idx_t  ext_wr_phy,
    input  cpu_types_pkg::word_t     ext_wr_value,

    output logic                     cdb_valid,
    output cpu_types_pkg::prf_idx_t  cdb_rd_phy,
    output cpu_types_pkg::word_t     cdb_value,

    output logic                     resolve_valid,
    output cpu_types_pkg::rob_id_t   resolve_rob_id,
    output logic                     resolve_taken,
    output cpu_types_pkg::word_t     resolve_target,
    output logic                     resolve_mispredict
);
    import cpu_types_pkg::*;

    ////////////////////////////////////////////////////////////
    // broadcast lanes
    ////////////////////////////////////////////////////////////

    logic     lane_valid [`CDB_WIDTH];
    prf_idx_t lane_phy   [`CDB_WIDTH];
    word_t    lane_value [`CDB_WIDTH];

    prf_idx_t rd1_phy;
    prf_idx_t rd2_phy;
    word_t    rd1_value;
    word_t    rd2_value;

    // lane 0 link write from the branch unit
    assign lane_valid[0] = cdb_valid;
    assign lane_phy[0]   = cdb_rd_phy;
    assign lane_value[0] = cdb_value;

    // lane 1 stands in for the other units
    assign lane_valid[1] = ext_wr_valid;
    assign lane_phy[1]   = ext_wr_phy;
    assign lane_value[1] = ext_wr_value;

    br_rs rs_i (
        .clk                (clk),
        .rst                (rst),
        .branch_ready       (branch_ready),
        .disp_valid         (disp_valid),
        .disp_ready         (disp_ready),
        .disp_rob_id        (disp_rob_id),
        .disp_rs1_phy       (disp_rs1_phy),
        .disp_rs1_ready     (disp_rs1_ready),
        .disp_rs2_phy       (disp_rs2_phy),
        .disp_rs2_ready     (disp_rs2_ready),
        .disp_rd_phy        (disp_rd_phy),
        .disp_rd_arch       (disp_rd_arch),
        .disp_imm           (disp_imm),
        .disp_pc            (disp_pc),
        .disp_op            (disp_op),
        .disp_pred_taken    (disp_pred_taken),
        .disp_pred_target   (disp_pred_target),
        .lane_valid         (lane_valid),
        .lane_phy           (lane_phy),
        .lane_value         (lane_value),
        .rd1_phy            (rd1_phy),
        .rd2_phy            (rd2_phy),
        .rd1_value          (rd1_value),
        .rd2_value          (rd2_value),
        .cdb_valid          (cdb_valid),
        .cdb_rd_phy         (cdb_rd_phy),
        .cdb_value          (cdb_value),
        .resolve_valid      (resolve_valid),
        .resolve_rob_id     (resolve_rob_id),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_mispredict (resolve_mispredict)
    );

    prf_regs prf_i (
        .clk        (clk),
        .rst        (rst),
        .lane_valid (lane_valid),
        .lane_phy   (lane_phy),
        .lane_value (lane_value),
        .rd1_phy    (rd1_phy),
        .rd2_phy    (rd2_phy),
        .rd1_value  (rd1_value),
        .rd2_value  (rd2_value)
    );

endmodule

`default_nettype wire

//--- sim/br_issue_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_consts.svh"

module br_rs_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    push_en,
    input logic [`BR_RS_IDX-1:0]   push_idx,
    input logic [`BR_RS_DEPTH-1:0] slot_free,
    input logic                    disp_ready,
    input logic                    issue_valid,
    input logic                    resolve_valid,
    input logic                    cdb_valid
);

    // a push lands in a free slot, never in a full station
    push_into_free_slot: assert property (@(posedge clk) disable iff (rst)
        push_en |-> slot_free[push_idx])
        else $error("push aimed at an occupied station slot");

    push_occupies_slot: assert property (@(posedge clk) disable iff (rst)
        push_en |=> !slot_free[$past(push_idx)])
        else $error("pushed slot still marked free after the push");

    // branch unit latency is exactly one cycle
    resolve_after_issue: assert property (@(posedge clk) disable iff (rst)
        issue_valid |=> resolve_valid)
        else $error("issue was not followed by a resolve");

    no_resolve_without_issue: assert property (@(posedge clk) disable iff (rst)
        !issue_valid |=> !resolve_valid)
        else $error("resolve without an issue in the cycle before");

    link_only_with_resolve: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> resolve_valid)
        else $error("link write seen without a resolve");

    ready_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> disp_ready)
        else $error("station not ready in the first cycle after reset");

endmodule

bind br_rs br_rs_sva rs_checks (
    .clk           (clk),
    .rst           (rst),
    .push_en       (push_en),
    .push_idx      (push_idx),
    .slot_free     (slot_free),
    .disp_ready    (disp_ready),
    .issue_valid   (issue_valid),
    .resolve_valid (resolve_valid),
    .cdb_valid     (cdb_valid)
);

`default_nettype wire

//--- sim/br_issue_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_consts.svh"

module br_issue_tb;
    import cpu_types_pkg::*;
    import br_uop_pkg::*;

    // model state of each physical register
    localparam logic [1:0] ST_FREE  = 2'd0;
    localparam logic [1:0] ST_AWAIT = 2'd1;  // waited on, only the ext port writes it
    localparam logic [1:0] ST_LINK  = 2'd2;  // reserved as a link destination
    localparam logic [1:0] ST_DONE  = 2'd3;

    localparam int PH_STALL  = 0;
    localparam int PH_RANDOM = 1;
    localparam int PH_DRAIN  = 2;

    localparam br_op_t OP_TABLE [8] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
                                        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR};

    typedef struct packed {
        br_op_t   op;
        word_t    pc;
        word_t    imm;
        prf_idx_t rs1;
        prf_idx_t rs2;
        prf_idx_t rd_phy;
        arf_idx_t rd_arch;
        logic     pred_taken;
        word_t    pred_target;
    } uop_rec_t;

    logic     clk, rst, branch_ready, disp_valid, disp_ready;
    rob_id_t  disp_rob_id;
    prf_idx_t disp_rs1_phy, disp_rs2_phy, disp_rd_phy;
    logic     disp_rs1_ready, disp_rs2_ready, disp_pred_taken;
    arf_idx_t disp_rd_arch;
    word_t    disp_imm, disp_pc, disp_pred_target;
    br_op_t   disp_op;
    logic     ext_wr_valid;
    prf_idx_t ext_wr_phy;
    word_t    ext_wr_value;
    logic     cdb_valid, resolve_valid, resolve_taken, resolve_mispredict;
    prf_idx_t cdb_rd_phy;
    word_t    cdb_value, resolve_target;
    rob_id_t  resolve_rob_id;

    logic [31:0] lfsr;
    int          errors, dispatched, resolved, phase, wait_cycles;
    logic        have_uop, ready_seen;
    rob_id_t     next_rob;
    word_t       model_val  [`PRF_DEPTH];
    logic [1:0]  reg_state  [`PRF_DEPTH];
    uop_rec_t    pend       [2**`ROB_IDX];
    logic        pend_valid [2**`ROB_IDX];

    br_issue_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t rand_word();
        word_t r;
        r = rand_bits(1);
        // small values make equal compares common
        if (r[0]) begin
            r = rand_bits(32);
        end else begin
            r = rand_bits(2);
        end
        return r;
    endfunction

    function automatic logic find_reg(input logic [1:0] state, output prf_idx_t idx);
        prf_idx_t start;
        start = prf_idx_t'(rand_bits(6));
        idx   = start;
        for (int i = 0; i < `PRF_DEPTH; i++) begin
            idx = start + prf_idx_t'(i);
            if (reg_state[idx] == state) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic prf_idx_t pick_source(input logic need_wait);
        prf_idx_t idx;
        idx = prf_idx_t'(rand_bits(6));
        if (need_wait) begin
            void'(find_reg(ST_FREE, idx));
        end
        if (reg_state[idx] == ST_FREE) begin
            reg_state[idx] = ST_AWAIT;
        end
        return idx;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic make_uop();
        logic [2:0] sel;
        prf_idx_t   idx;
        word_t      r;
        sel     = 3'(rand_bits(3));
        disp_op = (phase == PH_STALL) ? BR_BLTU : OP_TABLE[sel];
        disp_rob_id = next_rob;
        next_rob++;
        // jumps read only preloaded registers, except the jalr base
        if (disp_op == BR_JAL) begin
            disp_rs1_phy = prf_idx_t'(rand_bits(4));
        end else begin
            disp_rs1_phy = pick_source(phase == PH_STALL);
        end
        if (disp_op == BR_JAL || disp_op == BR_JALR) begin
            disp_rs2_phy = prf_idx_t'(rand_bits(4));
        end else begin
            disp_rs2_phy = pick_source(1'b0);
        end
        disp_rd_arch = arf_idx_t'(rand_bits(5));
        disp_rd_phy  = prf_idx_t'(rand_bits(6));
        if (disp_op == BR_JAL || disp_op == BR_JALR) begin
            if (find_reg(ST_FREE, idx) && disp_rd_arch != '0) begin
                disp_rd_phy    = idx;
                reg_state[idx] = ST_LINK;
            end else begin
                disp_rd_arch = '0;
            end
        end
        r        = rand_bits(30);
        disp_pc  = r << 2;
        r        = rand_bits(12);
        disp_imm = {{20{r[11]}}, r[11:1], 1'b0};
        r        = rand_bits(1);
        disp_pred_taken = r[0];
        r        = rand_bits(1);
        if (r[0]) begin
            disp_pred_target = disp_pc + disp_imm;
        end else begin
            disp_pred_target = rand_bits(32);
        end
        have_uop = 1'b1;
    endtask

    task automatic drive_inputs();
        prf_idx_t idx;
        logic [31:0] r;
        ext_wr_valid = 1'b0;
        r = rand_bits(1);
        if (phase != PH_STALL && r[0] && find_reg(ST_AWAIT, idx)) begin
            ext_wr_valid   = 1'b1;
            ext_wr_phy     = idx;
            ext_wr_value   = rand_word();
            model_val[idx] = ext_wr_value;
            reg_state[idx] = ST_DONE;
        end
        r = rand_bits(2);
        branch_ready = (phase == PH_STALL) || (r[1:0] != 2'b00);
        r = rand_bits(2);
        if (!have_uop && phase != PH_DRAIN && (phase == PH_STALL || r[1:0] != 2'b00)) begin
            make_uop();
        end
        // a held micro-op sees its sources turn ready
        disp_valid     = have_uop;
        disp_rs1_ready = (reg_state[disp_rs1_phy] == ST_DONE);
        disp_rs2_ready = (reg_state[disp_rs2_phy] == ST_DONE);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    task automatic check_resolve();
        rob_id_t  id;
        uop_rec_t u;
        word_t    a, b, exp_target;
        logic     exp_taken, exp_mis, exp_link;
        id = resolve_rob_id;
        assert (pend_valid[id])
            else report_error($sformatf("resolve for rob_id %0d which is not outstanding", id));
        if (pend_valid[id]) begin
            u = pend[id];
            pend_valid[id] = 1'b0;
            resolved++;
            assert (reg_state[u.rs1] == ST_DONE && reg_state[u.rs2] == ST_DONE)
                else report_error($sformatf("rob_id %0d resolved before its sources", id));
            a = model_val[u.rs1];
            b = model_val[u.rs2];
            case (u.op)
                BR_BEQ:  exp_taken = (a == b);
                BR_BNE:  exp_taken = (a != b);
                BR_BLT:  exp_taken = ($signed(a) < $signed(b));
                BR_BGE:  exp_taken = !($signed(a) < $signed(b));
                BR_BLTU: exp_taken = (a < b);
                BR_BGEU: exp_taken = !(a < b);
                default: exp_taken = 1'b1;
            endcase
            if (u.op == BR_JALR) begin
                exp_target = (a + u.imm) & ~32'h1;
            end else begin
                exp_target = exp_taken ? u.pc + u.imm : u.pc + 32'd4;
            end
            exp_mis  = (u.pred_taken != exp_taken)
                || (exp_taken && u.pred_target != exp_target);
            exp_link = (u.op == BR_JAL || u.op == BR_JALR) && u.rd_arch != '0;
            assert (resolve_taken === exp_taken)
                else report_mismatch($sformatf("rob %0d taken %b, expected %b",
                    id, resolve_taken, exp_taken));
            assert (resolve_target === exp_target)
                else report_mismatch($sformatf("rob %0d target %h, expected %h",
                    id, resolve_target, exp_target));
            assert (resolve_mispredict === exp_mis)
                else report_mismatch($sformatf("rob %0d mispredict %b, expected %b",
                    id, resolve_mispredict, exp_mis));
            assert (cdb_valid === exp_link)
                else report_mismatch($sformatf("rob %0d link valid %b, expected %b",
                    id, cdb_valid, exp_link));
            if (exp_link) begin
                assert (cdb_rd_phy === u.rd_phy && cdb_value === u.pc + 32'd4)
                    else report_mismatch($sformatf("rob %0d link p%0d=%h, expected p%0d=%h",
                        id, cdb_rd_phy, cdb_value, u.rd_phy, u.pc + 32'd4));
                model_val[u.rd_phy] = u.pc + 32'd4;
                reg_state[u.rd_phy] = ST_DONE;
            end
        end
    endtask

    // one clock: log the push, sample at +1, drive at +2
    task automatic step_cycle();
        @(posedge clk);
        if (disp_valid && ready_seen && branch_ready) begin
            pend_valid[disp_rob_id] = 1'b1;
            pend[disp_rob_id] = '{disp_op, disp_pc, disp_imm, disp_rs1_phy, disp_rs2_phy,
                                  disp_rd_phy, disp_rd_arch, disp_pred_taken, disp_pred_target};
            dispatched++;
            have_uop = 1'b0;
        end
        #1;
        ready_seen = disp_ready;
        if (resolve_valid) begin
            check_resolve();
        end else begin
            assert (!cdb_valid) else report_error("link write without a resolve");
        end
        #1;
        drive_inputs();
    endtask

    initial begin
        lfsr       = 32'd83418;
        errors     = 0;
        dispatched = 0;
        resolved   = 0;
        phase      = PH_STALL;
        next_rob   = '0;
        have_uop   = 1'b0;
        ready_seen = 1'b0;
        for (int i = 0; i < `PRF_DEPTH; i++) begin
            reg_state[i] = ST_FREE;
            model_val[i] = '0;
        end
        for (int i = 0; i < 2**`ROB_IDX; i++) begin
            pend_valid[i] = 1'b0;
        end
        rst = 1'b1;
        branch_ready = 1'b0;
        disp_valid = 1'b0;
        disp_rob_id = '0;
        disp_rs1_phy = '0;
        disp_rs1_ready = 1'b0;
        disp_rs2_phy = '0;
        disp_rs2_ready = 1'b0;
        disp_rd_phy = '0;
        disp_rd_arch = '0;
        disp_imm = '0;
        disp_pc = '0;
        disp_op = BR_BEQ;
        disp_pred_taken = 1'b0;
        disp_pred_target = '0;
        ext_wr_valid = 1'b0;
        ext_wr_phy = '0;
        ext_wr_value = '0;

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #1;
        ready_seen = disp_ready;
        assert (disp_ready && !resolve_valid && !cdb_valid)
            else report_mismatch("outputs not idle after reset");

        // preload p0..p15 through the external port
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #2;
            ext_wr_valid = 1'b1;
            ext_wr_phy   = prf_idx_t'(i);
            ext_wr_value = rand_word();
            model_val[ext_wr_phy] = ext_wr_value;
            reg_state[ext_wr_phy] = ST_DONE;
        end

        // fill every slot with micro-ops waiting on unwritten sources
        repeat (12) step_cycle();
        assert (!disp_ready && dispatched == `BR_RS_DEPTH && resolved == 0)
            else report_mismatch($sformatf("full station: ready %b, pushed %0d, resolved %0d",
                disp_ready, dispatched, resolved));

        phase = PH_RANDOM;
        repeat (240) step_cycle();

        phase = PH_DRAIN;
        wait_cycles = 0;
        while ((have_uop || dispatched != resolved) && wait_cycles < 2000) begin
            step_cycle();
            wait_cycles++;
        end
        if (have_uop || dispatched != resolved) begin
            report_error("timeout waiting for outstanding micro-ops to resolve");
        end
        for (int i = 0; i < 2**`ROB_IDX; i++) begin
            assert (!pend_valid[i])
                else report_error($sformatf("rob_id %0d never resolved", i));
        end

        $display("errors %0d, dispatched %0d, resolved %0d", errors, dispatched, resolved);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- br_issue_top.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/br_uop_pkg.sv
logic/fu_br.sv
logic/prf_regs.sv
logic/br_rs.sv
logic/br_issue_top.sv
sim/br_issue_sva.sv
sim/br_issue_tb.sv

//--- Makefile
# Verilator build and run for the branch issue slice

VERILATOR  ?= verilator
TOP        ?= br_issue_tb
FILELIST   ?= br_issue_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert --timing
SEED_FLAGS ?= +verilator+seed+83418
PASS_TEXT  ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := logic/br_consts.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) $(SEED_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
